/* core_settings.svh */
// ==================================================
// Global settings of the multi-cycle RV32I core
// Widths, reset vector and major opcode values
// ==================================================

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_XLEN          32
`define CORE_NREGS         32
`define CORE_REG_AW        5
`define CORE_RESET_VECTOR  32'h0000_0000

// Major opcodes, bits [6:0] of the instruction
`define CORE_OPC_OP        7'b0110011
`define CORE_OPC_OP_IMM    7'b0010011
`define CORE_OPC_LUI       7'b0110111
`define CORE_OPC_AUIPC     7'b0010111
`define CORE_OPC_JAL       7'b1101111
`define CORE_OPC_JALR      7'b1100111
`define CORE_OPC_BRANCH    7'b1100011

`endif

/* core_pkg.sv */
// ==================================================
// Shared types of the multi-cycle RV32I core
// Word types, control enums and packed records
// ==================================================

`include "core_settings.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0]   word_t;
	typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_e;
	typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
	} branch_e;

	typedef enum logic [1:0] {ST_FETCH, ST_WAIT, ST_EXEC, ST_HALT} core_state_e;

	// Decoded instruction as seen by execute and writeback
	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     imm;
		alu_op_e   alu_op;
		src_a_e    src_a;
		src_b_e    src_b;
		branch_e   branch;
		logic      jump_reg;
		logic      link;
		logic      invalid;
	} decoded_t;

	// One record per retired instruction
	typedef struct packed {
		word_t     pc;
		reg_addr_t rd;
		word_t     wdata;
	} retire_t;

endpackage

/* core_ctrl_fsm.sv */
// ==================================================
// Control FSM of the multi-cycle RV32I core
// Steps through fetch, wait and execute, and stops
// in halt on an invalid instruction
// ==================================================

module core_ctrl_fsm (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            imem_ready_i,
	input  logic            invalid_i,
	input  core_pkg::word_t imem_rdata_i,
	output logic            fetch_o,
	output logic            exec_o,
	output logic            halted_o,
	output core_pkg::word_t instr_o
);
	import core_pkg::*;

	core_state_e state_q;
	core_state_e state_d;
	logic        fetch_q;
	logic        latched_q;
	word_t       instr_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_FETCH: begin
				// Leave once the request pulse has gone out
				if (fetch_q) begin
					state_d = ST_WAIT;
				end
			end
			ST_WAIT: begin
				// Decode looks at the captured word one cycle after ready
				if (latched_q) begin
					state_d = invalid_i ? ST_HALT : ST_EXEC;
				end
			end
			ST_EXEC: state_d = ST_FETCH;
			default: state_d = ST_HALT;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= ST_FETCH;
			fetch_q   <= 1'b0;
			latched_q <= 1'b0;
		end else begin
			state_q   <= state_d;
			fetch_q   <= (state_d == ST_FETCH) && !fetch_q;
			latched_q <= (state_q == ST_WAIT) && imem_ready_i && !latched_q;
		end
	end

	// Instruction register
	always_ff @(posedge clk) begin
		if (state_q == ST_WAIT && imem_ready_i) begin
			instr_q <= imem_rdata_i;
		end
	end

	assign fetch_o  = fetch_q;
	assign exec_o   = (state_q == ST_EXEC);
	assign halted_o = (state_q == ST_HALT);
	assign instr_o  = instr_q;

endmodule

/* core_counters.sv */
// ==================================================
// Program counter and retired-instruction counter
// Both advance at the end of each execute cycle
// ==================================================

`include "core_settings.svh"

module core_counters (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            exec_i,
	input  core_pkg::word_t next_pc_i,
	output core_pkg::word_t pc_o,
	output core_pkg::word_t instret_o
);

	// ==================================================
	// Program counter
	// ==================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_o <= `CORE_RESET_VECTOR;
		end else if (exec_i) begin
			pc_o <= next_pc_i;
		end
	end

	// ==================================================
	// Retired instructions
	// ==================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instret_o <= '0;
		end else if (exec_i) begin
			// One retire per execute cycle
			instret_o <= instret_o + 1'b1;
		end
	end

endmodule

/* core_decode.sv */
// ==================================================
// RV32I integer decoder
// Builds the control record and flags anything
// outside the supported subset as invalid
// ==================================================

`include "core_settings.svh"

module core_decode (
	input  core_pkg::word_t    instr_i,
	output core_pkg::decoded_t dec_o
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_u;
	word_t      imm_b;
	word_t      imm_j;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// Immediate formats
	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_u = {instr_i[31:12], 12'h000};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// Shared funct3 map of OP and OP-IMM, alt selects SUB and SRA
	function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		// Register-register ALU form by default
		dec_o.rs1      = instr_i[19:15];
		dec_o.rs2      = instr_i[24:20];
		dec_o.rd       = instr_i[11:7];
		dec_o.imm      = imm_i;
		dec_o.alu_op   = ALU_ADD;
		dec_o.src_a    = SRC_A_RS1;
		dec_o.src_b    = SRC_B_RS2;
		dec_o.branch   = BR_NONE;
		dec_o.jump_reg = 1'b0;
		dec_o.link     = 1'b0;
		dec_o.invalid  = 1'b0;

		case (opcode)
			`CORE_OPC_LUI: begin
				dec_o.imm   = imm_u;
				dec_o.src_a = SRC_A_ZERO;
				dec_o.src_b = SRC_B_IMM;
			end
			`CORE_OPC_AUIPC: begin
				dec_o.imm   = imm_u;
				dec_o.src_a = SRC_A_PC;
				dec_o.src_b = SRC_B_IMM;
			end
			`CORE_OPC_JAL: begin
				dec_o.imm    = imm_j;
				dec_o.branch = BR_JUMP;
				dec_o.link   = 1'b1;
			end
			`CORE_OPC_JALR: begin
				dec_o.branch   = BR_JUMP;
				dec_o.jump_reg = 1'b1;
				dec_o.link     = 1'b1;
				dec_o.invalid  = (funct3 != 3'b000);
			end
			`CORE_OPC_BRANCH: begin
				dec_o.imm = imm_b;
				dec_o.rd  = '0;
				case (funct3)
					3'b000:  dec_o.branch = BR_EQ;
					3'b001:  dec_o.branch = BR_NE;
					3'b100:  dec_o.branch = BR_LT;
					3'b101:  dec_o.branch = BR_GE;
					3'b110:  dec_o.branch = BR_LTU;
					3'b111:  dec_o.branch = BR_GEU;
					default: dec_o.invalid = 1'b1;
				endcase
			end
			`CORE_OPC_OP_IMM: begin
				dec_o.src_b  = SRC_B_IMM;
				dec_o.alu_op = funct3_op(funct3, (funct3 == 3'b101) && funct7[5]);
				// Shift immediates only allow funct7 of zero, or bit 5 for SRAI
				if (funct3 == 3'b001) begin
					dec_o.invalid = (funct7 != 7'b0000000);
				end else if (funct3 == 3'b101) begin
					dec_o.invalid = ({funct7[6], funct7[4:0]} != 6'b000000);
				end
			end
			`CORE_OPC_OP: begin
				dec_o.alu_op  = funct3_op(funct3, funct7[5]);
				dec_o.invalid = !((funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			default: dec_o.invalid = 1'b1;
		endcase
	end

endmodule

/* core_regfile.sv */
// ==================================================
// Integer register file, one write and two read ports
// x0 is hard-wired to zero
// ==================================================

`include "core_settings.svh"

module core_regfile (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                we_i,
	input  core_pkg::reg_addr_t waddr_i,
	input  core_pkg::word_t     wdata_i,
	input  core_pkg::reg_addr_t raddr1_i,
	input  core_pkg::reg_addr_t raddr2_i,
	output core_pkg::word_t     rdata1_o,
	output core_pkg::word_t     rdata2_o
);
	import core_pkg::*;

	// No storage behind x0
	word_t regs [1:`CORE_NREGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Asynchronous reads
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* core_execute.sv */
// ==================================================
// Execute stage of the multi-cycle RV32I core
// ALU, branch compare and next-PC selection
// ==================================================

module core_execute (
	input  core_pkg::decoded_t dec_i,
	input  core_pkg::word_t    pc_i,
	input  core_pkg::word_t    rs1_i,
	input  core_pkg::word_t    rs2_i,
	output core_pkg::word_t    wdata_o,
	output core_pkg::word_t    next_pc_o
);
	import core_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t alu_res;
	word_t pc_plus4;
	word_t target;
	logic  taken;

	// ==================================================
	// Operands and ALU
	// ==================================================

	always_comb begin
		case (dec_i.src_a)
			SRC_A_RS1: op_a = rs1_i;
			SRC_A_PC:  op_a = pc_i;
			default:   op_a = '0;
		endcase
		op_b = (dec_i.src_b == SRC_B_IMM) ? dec_i.imm : rs2_i;
	end

	always_comb begin
		case (dec_i.alu_op)
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << op_b[4:0];
			ALU_SLT:  alu_res = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLTU: alu_res = word_t'(op_a < op_b);
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> op_b[4:0];
			ALU_SRA:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			default:  alu_res = op_a + op_b;
		endcase
	end

	// ==================================================
	// Branch resolution
	// ==================================================

	// Compare is separate from the ALU, which stays free for the result
	always_comb begin
		case (dec_i.branch)
			BR_EQ:   taken = (rs1_i == rs2_i);
			BR_NE:   taken = (rs1_i != rs2_i);
			BR_LT:   taken = ($signed(rs1_i) < $signed(rs2_i));
			BR_GE:   taken = ($signed(rs1_i) >= $signed(rs2_i));
			BR_LTU:  taken = (rs1_i < rs2_i);
			BR_GEU:  taken = (rs1_i >= rs2_i);
			BR_JUMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign pc_plus4 = pc_i + word_t'(4);

	// JALR clears bit 0 of the sum
	assign target = dec_i.jump_reg ? ((rs1_i + dec_i.imm) & ~word_t'(1)) : (pc_i + dec_i.imm);

	assign next_pc_o = taken ? target : pc_plus4;
	assign wdata_o   = dec_i.link ? pc_plus4 : alu_res;

endmodule

/* core_top.sv */
// ==================================================
// Top level of the multi-cycle RV32I core
// Instruction port in, retire record out
// ==================================================

module core_top (
	input  logic              clk,
	input  logic              rst_n,
	output logic              imem_req_o,
	output core_pkg::word_t   imem_addr_o,
	input  logic              imem_ready_i,
	input  core_pkg::word_t   imem_rdata_i,
	output logic              retire_valid_o,
	output core_pkg::retire_t retire_o,
	output core_pkg::word_t   instret_o,
	output logic              halted_o
);
	import core_pkg::*;

	logic     fetch;
	logic     exec;
	word_t    instr;
	decoded_t dec;
	word_t    pc;
	word_t    next_pc;
	word_t    rs1_val;
	word_t    rs2_val;
	word_t    wdata;

	core_ctrl_fsm i_ctrl_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_ready_i (imem_ready_i),
		.invalid_i    (dec.invalid),
		.imem_rdata_i (imem_rdata_i),
		.fetch_o      (fetch),
		.exec_o       (exec),
		.halted_o     (halted_o),
		.instr_o      (instr)
	);

	core_counters i_counters (
		.clk       (clk),
		.rst_n     (rst_n),
		.exec_i    (exec),
		.next_pc_i (next_pc),
		.pc_o      (pc),
		.instret_o (instret_o)
	);

	core_decode i_decode (
		.instr_i (instr),
		.dec_o   (dec)
	);

	// Branches carry rd of zero, so the write is dropped
	core_regfile i_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.we_i     (exec),
		.waddr_i  (dec.rd),
		.wdata_i  (wdata),
		.raddr1_i (dec.rs1),
		.raddr2_i (dec.rs2),
		.rdata1_o (rs1_val),
		.rdata2_o (rs2_val)
	);

	core_execute i_execute (
		.dec_i     (dec),
		.pc_i      (pc),
		.rs1_i     (rs1_val),
		.rs2_i     (rs2_val),
		.wdata_o   (wdata),
		.next_pc_o (next_pc)
	);

	assign imem_req_o  = fetch;
	assign imem_addr_o = pc;

	assign retire_valid_o = exec;
	assign retire_o.pc    = pc;
	assign retire_o.rd    = dec.rd;
	assign retire_o.wdata = wdata;

endmodule

/* core_tb_tasks.svh */
// ==================================================
// Instruction encoders, compare tasks and directed
// tests of the RV32I core testbench
// ==================================================

// ==================================================
// Instruction encoders
// ==================================================

function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2, rs1,
	input logic [2:0] f3, input reg_addr_t rd);
	return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
endfunction

function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
	input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
	input logic [6:0] opc);
	return {imm, rd, opc};
endfunction

function automatic word_t b_type(input logic [12:0] off, input reg_addr_t rs2, rs1,
	input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `CORE_OPC_BRANCH};
endfunction

function automatic word_t j_type(input logic [20:0] off, input reg_addr_t rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, `CORE_OPC_JAL};
endfunction

// ==================================================
// Compare tasks
// ==================================================

task automatic check_word(input string name, input word_t got, input word_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %0t %s got x%0d expected x%0d", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
	end
endtask

task automatic check_retire(input int idx, input retire_t got, input retire_t exp);
	check_word($sformatf("retire[%0d].pc", idx), got.pc, exp.pc);
	check_reg($sformatf("retire[%0d].rd", idx), got.rd, exp.rd);
	// Nothing is written back when rd is zero
	if (exp.rd != '0) begin
		check_word($sformatf("retire[%0d].wdata", idx), got.wdata, exp.wdata);
	end
endtask

// ==================================================
// Program building
// ==================================================

task automatic new_program();
	// Fill words carry opcode zero and decode as invalid
	for (int i = 0; i < 256; i++) begin
		mem[i] = {i[24:0], 7'b0000000};
	end
	exp_q.delete();
	load_addr = `CORE_RESET_VECTOR;
endtask

task automatic place_skipped(input word_t instr);
	mem[load_addr[9:2]] = instr;
	load_addr = load_addr + 4;
endtask

task automatic place(input word_t instr, input reg_addr_t rd, input word_t wdata);
	retire_t rec;
	rec.pc    = load_addr;
	rec.rd    = rd;
	rec.wdata = wdata;
	exp_q.push_back(rec);
	place_skipped(instr);
endtask

// ECALL is outside the supported set and stops the core
task automatic end_program();
	place_skipped(32'h0000_0073);
endtask

// Branch by +8, a taken branch jumps over one filler word
task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs1, rs2, input logic taken);
	place(b_type(13'd8, rs2, rs1, f3), 0, '0);
	if (taken) begin
		place_skipped(i_type(12'd99, 0, 3'd0, 5, `CORE_OPC_OP_IMM));
	end
endtask

// ==================================================
// Directed tests
// ==================================================

task automatic after_reset();
	int cycles;
	new_program();
	@(negedge clk);
	rst_n = 1'b0;
	@(negedge clk);
	check_bit("imem_req_o", imem_req, 1'b0);
	check_bit("retire_valid_o", retire_valid, 1'b0);
	check_bit("halted_o", halted, 1'b0);
	repeat (3) @(negedge clk);
	rst_n  = 1'b1;
	cycles = 0;
	while (!imem_req && cycles < 20) begin
		@(negedge clk);
		cycles++;
	end
	if (!imem_req) begin
		errors++;
		$display("ERROR at %0t: no instruction request after reset", $time);
	end
	check_word("imem_addr_o", imem_addr, `CORE_RESET_VECTOR);
	check_bit("retire_valid_o", retire_valid, 1'b0);
	check_bit("halted_o", halted, 1'b0);
endtask

task automatic alu_ops();
	new_program();
	// x1 = -5, x2 = 3
	place(i_type(12'hFFB, 0, 3'd0, 1, `CORE_OPC_OP_IMM), 1, 32'hFFFF_FFFB);
	place(i_type(12'h003, 0, 3'd0, 2, `CORE_OPC_OP_IMM), 2, 32'h0000_0003);
	// slt, sltu, sra, srl, sub, sll, xor, or, and, add
	place(r_type(7'h00, 2, 1, 3'd2, 3), 3, 32'h0000_0001);
	place(r_type(7'h00, 2, 1, 3'd3, 4), 4, 32'h0000_0000);
	place(r_type(7'h20, 2, 1, 3'd5, 5), 5, 32'hFFFF_FFFF);
	place(r_type(7'h00, 2, 1, 3'd5, 6), 6, 32'h1FFF_FFFF);
	place(r_type(7'h20, 1, 2, 3'd0, 7), 7, 32'h0000_0008);
	place(r_type(7'h00, 2, 2, 3'd1, 8), 8, 32'h0000_0018);
	place(r_type(7'h00, 2, 1, 3'd4, 9), 9, 32'hFFFF_FFF8);
	place(r_type(7'h00, 2, 1, 3'd6, 10), 10, 32'hFFFF_FFFB);
	place(r_type(7'h00, 2, 1, 3'd7, 11), 11, 32'h0000_0003);
	place(r_type(7'h00, 2, 1, 3'd0, 12), 12, 32'hFFFF_FFFE);
	// slti, sltiu, xori, ori, andi, slli, srli, srai
	place(i_type(12'hFFB, 2, 3'd2, 13, `CORE_OPC_OP_IMM), 13, 32'h0000_0000);
	place(i_type(12'hFFF, 2, 3'd3, 14, `CORE_OPC_OP_IMM), 14, 32'h0000_0001);
	place(i_type(12'h0F0, 1, 3'd4, 15, `CORE_OPC_OP_IMM), 15, 32'hFFFF_FF0B);
	place(i_type(12'h100, 2, 3'd6, 16, `CORE_OPC_OP_IMM), 16, 32'h0000_0103);
	place(i_type(12'h0FF, 1, 3'd7, 17, `CORE_OPC_OP_IMM), 17, 32'h0000_00FB);
	place(i_type(12'h004, 2, 3'd1, 18, `CORE_OPC_OP_IMM), 18, 32'h0000_0030);
	place(i_type(12'h01C, 1, 3'd5, 19, `CORE_OPC_OP_IMM), 19, 32'h0000_000F);
	place(i_type(12'h401, 1, 3'd5, 20, `CORE_OPC_OP_IMM), 20, 32'hFFFF_FFFD);
	// Write to x0, then read it back through add
	place(i_type(12'h007, 2, 3'd0, 0, `CORE_OPC_OP_IMM), 0, 32'h0000_000A);
	place(r_type(7'h00, 2, 0, 3'd0, 21), 21, 32'h0000_0003);
	end_program();
	run_program();
endtask

task automatic upper_immediates();
	new_program();
	place(u_type(20'h12345, 1, `CORE_OPC_LUI), 1, 32'h1234_5000);
	place(u_type(20'h00010, 2, `CORE_OPC_AUIPC), 2, 32'h0001_0004);
	place(u_type(20'hFFFFF, 3, `CORE_OPC_AUIPC), 3, 32'hFFFF_F008);
	place(u_type(20'h80000, 4, `CORE_OPC_LUI), 4, 32'h8000_0000);
	end_program();
	run_program();
endtask

task automatic branches_and_jumps();
	word_t at;
	word_t jal_link;
	new_program();
	// x1 = -1, x2 = 1
	place(i_type(12'hFFF, 0, 3'd0, 1, `CORE_OPC_OP_IMM), 1, 32'hFFFF_FFFF);
	place(i_type(12'h001, 0, 3'd0, 2, `CORE_OPC_OP_IMM), 2, 32'h0000_0001);
	branch_case(3'd0, 1, 2, 1'b0);
	branch_case(3'd0, 1, 1, 1'b1);
	branch_case(3'd1, 1, 2, 1'b1);
	branch_case(3'd1, 2, 2, 1'b0);
	branch_case(3'd4, 1, 2, 1'b1);
	branch_case(3'd4, 2, 1, 1'b0);
	branch_case(3'd5, 2, 1, 1'b1);
	branch_case(3'd5, 1, 2, 1'b0);
	branch_case(3'd6, 2, 1, 1'b1);
	branch_case(3'd6, 1, 2, 1'b0);
	branch_case(3'd7, 1, 2, 1'b1);
	branch_case(3'd7, 2, 1, 1'b0);
	// jal x3 over two filler words
	at       = load_addr;
	jal_link = at + 4;
	place(j_type(21'd12, 3), 3, jal_link);
	place_skipped(i_type(12'd99, 0, 3'd0, 5, `CORE_OPC_OP_IMM));
	place_skipped(i_type(12'd99, 0, 3'd0, 5, `CORE_OPC_OP_IMM));
	// jalr x4 with x2 = 1, so the sum is odd and bit 0 is cleared
	at = load_addr;
	place(i_type(12'(at + 16), 2, 3'd0, 4, `CORE_OPC_JALR), 4, at + 4);
	repeat (3) place_skipped(i_type(12'd99, 0, 3'd0, 5, `CORE_OPC_OP_IMM));
	place(i_type(12'h000, 3, 3'd0, 6, `CORE_OPC_OP_IMM), 6, jal_link);
	end_program();
	run_program();
endtask

task automatic invalid_halts();
	new_program();
	place(i_type(12'h007, 0, 3'd0, 1, `CORE_OPC_OP_IMM), 1, 32'h0000_0007);
	place(i_type(12'h001, 1, 3'd0, 2, `CORE_OPC_OP_IMM), 2, 32'h0000_0008);
	// MUL from the M extension, then a word that must never run
	place_skipped(r_type(7'h01, 2, 1, 3'd0, 3));
	place_skipped(i_type(12'h001, 0, 3'd0, 3, `CORE_OPC_OP_IMM));
	run_program();
	check_bit("halted_o", halted, 1'b1);
	repeat (20) @(negedge clk);
	check_bit("halted_o", halted, 1'b1);
	check_word("instret_o", instret, word_t'(got_q.size()));
endtask

/* core_tb.sv */
// ==================================================
// Testbench of the multi-cycle RV32I core
// Instruction memory with random latency, retire
// monitor, watchdog and the directed test sequence
// ==================================================

`include "core_settings.svh"

module core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import core_pkg::*;

	logic    clk;
	logic    rst_n;
	logic    imem_req;
	word_t   imem_addr;
	logic    imem_ready;
	word_t   imem_rdata;
	logic    retire_valid;
	retire_t retire;
	word_t   instret;
	logic    halted;

	// Program image and the expected and observed retire records
	word_t   mem [256];
	word_t   load_addr;
	retire_t exp_q [$];
	retire_t got_q [$];

	int num_tests = 5;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int start_errors;

	// Memory model state
	logic  mem_pending;
	int    mem_delay;
	word_t mem_addr;

	core_top i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.imem_req_o     (imem_req),
		.imem_addr_o    (imem_addr),
		.imem_ready_i   (imem_ready),
		.imem_rdata_i   (imem_rdata),
		.retire_valid_o (retire_valid),
		.retire_o       (retire),
		.instret_o      (instret),
		.halted_o       (halted)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ==================================================
	// Instruction memory, answers 1 to 3 cycles late
	// ==================================================

	initial begin
		void'($urandom(54));
		forever begin
			@(negedge clk);
			imem_ready = 1'b0;
			if (!rst_n) begin
				mem_pending = 1'b0;
			end else if (mem_pending) begin
				mem_delay--;
				if (mem_delay == 0) begin
					imem_ready  = 1'b1;
					imem_rdata  = mem[mem_addr[9:2]];
					mem_pending = 1'b0;
				end
			end else if (imem_req) begin
				mem_pending = 1'b1;
				mem_addr    = imem_addr;
				mem_delay   = 1 + ($urandom % 3);
			end
		end
	end

	// Retire monitor
	always @(negedge clk) begin
		if (rst_n) begin
			if (halted && (retire_valid || imem_req)) begin
				errors++;
				$display("ERROR at %0t: core still active after halting", $time);
			end
			if (retire_valid) begin
				got_q.push_back(retire);
			end
		end
	end

	initial begin
		repeat (num_tests * 400) @(posedge clk);
		$display("ERROR at %0t: watchdog expired after %0d cycles", $time, num_tests * 400);
		$display("TESTBENCH FAILED");
		$finish;
	end

	`include "core_tb_tasks.svh"

	task automatic pulse_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// Runs the loaded program up to its halt and compares the retire records
	task automatic run_program();
		int cycles;
		pulse_reset();
		got_q.delete();
		cycles = 0;
		while (!halted && cycles < 300) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			errors++;
			$display("ERROR at %0t: core did not halt within %0d cycles", $time, cycles);
		end
		repeat (10) @(negedge clk);
		check_word("retire count", word_t'(got_q.size()), word_t'(exp_q.size()));
		check_word("instret_o", instret, word_t'(got_q.size()));
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
			check_retire(i, got_q[i], exp_q[i]);
		end
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %-20s ok", name);
		end else begin
			tests_failed++;
			$display("test %-20s %0d errors", name, errors - start_errors);
		end
		start_errors = errors;
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		rst_n        = 1'b0;
		imem_ready   = 1'b0;
		imem_rdata   = '0;
		mem_pending  = 1'b0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		start_errors = 0;

		after_reset();
		close_test("after reset");
		alu_ops();
		close_test("alu ops");
		upper_immediates();
		close_test("upper immediates");
		branches_and_jumps();
		close_test("branches and jumps");
		invalid_halts();
		close_test("invalid halts");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+.
core_pkg.sv
core_ctrl_fsm.sv
core_counters.sv
core_decode.sv
core_regfile.sv
core_execute.sv
core_top.sv
core_tb.sv

/* Bender.yml */
package:
  name: rv32i_mc_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - core_ctrl_fsm.sv
      - core_counters.sv
      - core_decode.sv
      - core_regfile.sv
      - core_execute.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_tb.sv
